/* cnn_config.svh */
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// datapath widths
`define CNN_DATA_W      8
`define CNN_ADDR_W      8

// layer geometry
`define CNN_PIC_DIM     10
`define CNN_KER_DIM     5

// scratch memory map
`define CNN_PIC_BASE    0
`define CNN_KER_BASE    100
`define CNN_BIAS_ADDR   125
`define CNN_CONV_BASE   128
`define CNN_POOL_BASE   228

// host opcode bytes, ascii W R C
`define CNN_OP_WRITE    8'h57
`define CNN_OP_READ     8'h52
`define CNN_OP_CONV     8'h43

`endif

/* cnn_host_pkg.sv */
`include "cnn_config.svh"

package cnn_host_pkg;

    // opcode after decode of the first command byte
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_CONV  = 2'd2
    } host_op_t;

    // W and R: first byte start address, second byte length
    typedef struct packed {
        logic [`CNN_ADDR_W-1:0] addr;
        logic [`CNN_DATA_W-1:0] len;
    } xfer_args_t;

    // C: first byte flags, second byte unused
    typedef struct packed {
        logic [`CNN_DATA_W-1:0] flags;
        logic [`CNN_DATA_W-1:0] rsvd;
    } comp_args_t;

    typedef union packed {
        xfer_args_t xfer;
        comp_args_t comp;
    } cmd_args_u;

    typedef struct packed {
        logic      valid;
        host_op_t  op;
        cmd_args_u args;
    } host_cmd_t;

endpackage

/* cnn_layer_pkg.sv */
`include "cnn_config.svh"

package cnn_layer_pkg;

    typedef logic [`CNN_DATA_W-1:0] data_t;
    typedef logic [`CNN_ADDR_W-1:0] addr_t;

    // one scratch memory write
    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
    } mem_wr_t;

    // low bits of the C flags byte
    // bit 0 adds the bias, bit 1 runs the 2x2 max-pool
    typedef struct packed {
        logic max_pool;
        logic add_bias;
    } layer_flags_t;

endpackage

/* scratch_ram.sv */
`include "cnn_config.svh"

module scratch_ram
    import cnn_layer_pkg::*;
(
    input  logic    clk,
    input  mem_wr_t wr,
    input  addr_t   rd_addr,
    output data_t   rd_data
);

    localparam int DEPTH = 1 << `CNN_ADDR_W;

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];
    end

    // write address comes from the host decoder or the layer counters
    assert property (@(posedge clk) wr.valid |-> !$isunknown(wr.addr))
        else $error("scratch memory write with unknown address");

endmodule

/* cmd_decode.sv */
`include "cnn_config.svh"

module cmd_decode
    import cnn_host_pkg::*;
    import cnn_layer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  data_t     rx_data,
    input  logic      rx_rdy,
    output host_cmd_t cmd,
    output mem_wr_t   host_wr
);

    logic [1:0] hdr_cnt;
    logic       cmd_valid;
    host_op_t   op;
    host_op_t   op_dec;
    logic       op_ok;
    cmd_args_u  args;
    data_t      data_left;
    addr_t      wr_ptr;
    logic       wr_valid;
    addr_t      wr_addr;
    data_t      wr_data;

    assign cmd     = {cmd_valid, op, args};
    assign host_wr = {wr_valid, wr_addr, wr_data};

    always_comb begin
        op_ok  = 1'b1;
        op_dec = OP_WRITE;
        case (rx_data)
            `CNN_OP_WRITE: op_dec = OP_WRITE;
            `CNN_OP_READ:  op_dec = OP_READ;
            `CNN_OP_CONV:  op_dec = OP_CONV;
            default:       op_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hdr_cnt   <= '0;
            data_left <= '0;
            cmd_valid <= 1'b0;
            wr_valid  <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            wr_valid  <= 1'b0;
            if (rx_rdy) begin
                if (data_left != '0) begin
                    wr_valid  <= 1'b1;
                    data_left <= data_left - 1'b1;
                end else begin
                    case (hdr_cnt)
                        // stray bytes leave the counter at zero
                        2'd0: if (op_ok) hdr_cnt <= 2'd1;
                        2'd1: hdr_cnt <= 2'd2;
                        default: begin
                            hdr_cnt <= 2'd0;
                            if (op == OP_WRITE) begin
                                data_left <= rx_data;
                            end else begin
                                cmd_valid <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_rdy) begin
            if (data_left != '0) begin
                wr_addr <= wr_ptr;
                wr_data <= rx_data;
                wr_ptr  <= wr_ptr + 1'b1;
            end else if (hdr_cnt == 2'd0) begin
                op <= op_dec;
            end else if (hdr_cnt == 2'd1) begin
                args.xfer.addr <= rx_data;
            end else begin
                args.xfer.len <= rx_data;
                wr_ptr        <= args.xfer.addr;
            end
        end
    end

endmodule

/* layer_execute.sv */
`include "cnn_config.svh"

module layer_execute
    import cnn_host_pkg::*;
    import cnn_layer_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  host_cmd_t cmd,
    input  mem_wr_t   host_wr,
    input  logic      reply_ready,
    output data_t     reply_byte,
    output logic      reply_valid,
    output logic      busy
);

    localparam int PIC      = `CNN_PIC_DIM;
    localparam int KER      = `CNN_KER_DIM;
    localparam int PAD      = KER / 2;
    localparam int POOL     = PIC / 2;
    localparam int BIAS_IDX = KER * KER;

    typedef enum logic [2:0] {
        S_IDLE, S_READ, S_KLOAD, S_CONV, S_BIAS, S_POOL
    } state_t;

    state_t            state;
    state_t            next_pass;
    layer_flags_t      flags;
    addr_t             rd_ptr;
    data_t             rd_left;
    logic              rd_ok;
    logic              fire;
    logic [3:0]        row;
    logic [3:0]        col;
    logic [3:0]        out_end;
    logic [2:0]        tap_r;
    logic [2:0]        tap_c;
    logic [2:0]        tap_end;
    logic [4:0]        tap_idx;
    logic              tap_last;
    logic              out_last;
    logic              tap_in;
    logic signed [5:0] pr;
    logic signed [5:0] pc;
    logic              wr_phase;
    logic              p_ok;
    logic              p_kern;
    logic [4:0]        p_idx;
    data_t             coef [BIAS_IDX+1];
    data_t             acc;
    data_t             acc_next;
    data_t             prod;
    data_t             rd_data;
    addr_t             rd_addr;
    addr_t             tap_addr;
    addr_t             out_addr;
    mem_wr_t           mem_wr;

    scratch_ram ram_i (
        .clk     (clk),
        .wr      (mem_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    assign reply_valid = (state == S_READ) && rd_ok && (rd_left != '0);
    assign reply_byte  = rd_data;
    assign fire        = reply_valid && reply_ready;
    assign busy        = (state != S_IDLE) || cmd.valid;

    // tap position relative to the output pixel, padding of two
    assign tap_idx = 5'(tap_r * KER + tap_c);
    assign pr      = 6'($signed({2'b00, row}) + $signed({3'b000, tap_r}) - PAD);
    assign pc      = 6'($signed({2'b00, col}) + $signed({3'b000, tap_c}) - PAD);
    assign tap_in  = (pr >= 0) && (pr < PIC) && (pc >= 0) && (pc < PIC);
    assign prod    = rd_data * coef[p_idx];

    always_comb begin
        tap_end  = (state == S_POOL) ? 3'd1 : 3'(KER - 1);
        out_end  = (state == S_POOL) ? 4'(POOL - 1) : 4'(PIC - 1);
        out_last = (row == out_end) && (col == out_end);
        tap_last = (tap_r == tap_end) && (tap_c == tap_end);
        out_addr = addr_t'(`CNN_CONV_BASE + row * PIC + col);
        tap_addr = out_addr;
        case (state)
            S_KLOAD: begin
                // kernel then bias byte, 26 reads
                tap_last = (tap_idx == 5'(BIAS_IDX));
                tap_addr = tap_last ? addr_t'(`CNN_BIAS_ADDR)
                                    : addr_t'(`CNN_KER_BASE + tap_idx);
            end
            S_CONV: tap_addr = addr_t'(`CNN_PIC_BASE + pr * PIC + pc);
            S_BIAS: tap_last = 1'b1;
            S_POOL: begin
                tap_addr = addr_t'(`CNN_CONV_BASE + (2 * row + tap_r) * PIC + 2 * col + tap_c);
                out_addr = addr_t'(`CNN_POOL_BASE + row * POOL + col);
            end
            default: ;
        endcase
    end

    always_comb begin
        acc_next = acc;
        if (p_ok) begin
            case (state)
                S_CONV:  acc_next = acc + prod;
                S_BIAS:  acc_next = rd_data + coef[BIAS_IDX];
                S_POOL:  acc_next = (rd_data > acc) ? rd_data : acc;
                default: ;
            endcase
        end
    end

    always_comb begin
        next_pass = S_IDLE;
        if (state == S_CONV && flags.add_bias) begin
            next_pass = S_BIAS;
        end else if (state != S_POOL && flags.max_pool) begin
            next_pass = S_POOL;
        end
    end

    // read-out keeps rd_data on the current byte, one ahead after a handover
    always_comb begin
        if (state == S_READ) begin
            rd_addr = fire ? rd_ptr + 1'b1 : rd_ptr;
        end else begin
            rd_addr = tap_addr;
        end
        if (state == S_IDLE) begin
            mem_wr = host_wr;
        end else begin
            mem_wr = {wr_phase, out_addr, acc_next};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= S_IDLE;
            flags    <= '0;
            rd_ptr   <= '0;
            rd_left  <= '0;
            rd_ok    <= 1'b0;
            row      <= '0;
            col      <= '0;
            tap_r    <= '0;
            tap_c    <= '0;
            wr_phase <= 1'b0;
            acc      <= '0;
            p_ok     <= 1'b0;
            p_kern   <= 1'b0;
            p_idx    <= '0;
        end else begin
            p_ok   <= 1'b0;
            p_kern <= 1'b0;
            p_idx  <= tap_idx;
            case (state)
                S_IDLE: begin
                    if (cmd.valid && cmd.op == OP_READ) begin
                        rd_ptr  <= cmd.args.xfer.addr;
                        rd_left <= cmd.args.xfer.len;
                        rd_ok   <= 1'b0;
                        state   <= S_READ;
                    end else if (cmd.valid && cmd.op == OP_CONV) begin
                        flags    <= layer_flags_t'(cmd.args.comp.flags[1:0]);
                        row      <= '0;
                        col      <= '0;
                        tap_r    <= '0;
                        tap_c    <= '0;
                        wr_phase <= 1'b0;
                        acc      <= '0;
                        state    <= S_KLOAD;
                    end
                end
                S_READ: begin
                    rd_ok <= 1'b1;
                    if (fire) begin
                        rd_ptr  <= rd_ptr + 1'b1;
                        rd_left <= rd_left - 1'b1;
                    end
                    if (rd_left == '0 || (fire && rd_left == 8'd1)) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    acc <= acc_next;
                    if (wr_phase) begin
                        acc      <= '0;
                        wr_phase <= 1'b0;
                        if (out_last) begin
                            row   <= '0;
                            col   <= '0;
                            state <= next_pass;
                        end else if (col == out_end) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else begin
                        p_kern <= (state == S_KLOAD);
                        p_ok   <= (state == S_BIAS) || (state == S_POOL) ||
                                  (state == S_CONV && tap_in);
                        if (tap_last) begin
                            tap_r <= '0;
                            tap_c <= '0;
                            if (state == S_KLOAD) begin
                                state <= S_CONV;
                            end else begin
                                wr_phase <= 1'b1;
                            end
                        end else if (tap_c == tap_end) begin
                            tap_c <= '0;
                            tap_r <= tap_r + 1'b1;
                        end else begin
                            tap_c <= tap_c + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // kernel and bias capture
    always_ff @(posedge clk) begin
        if (p_kern) begin
            coef[p_idx] <= rd_data;
        end
    end

    // host waits for busy low before the next R or C
    assert property (@(posedge clk) disable iff (reset) cmd.valid |-> state == S_IDLE)
        else $error("command arrived while the layer engine was busy");

endmodule

/* reply_sender.sv */
module reply_sender
    import cnn_layer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  data_t reply_byte,
    input  logic  reply_valid,
    output logic  reply_ready,
    output data_t tx_data,
    output logic  tx_en,
    input  logic  tx_busy
);

    typedef enum logic [1:0] {S_EMPTY, S_HOLD, S_PULSE, S_SETTLE} state_t;

    state_t state;
    data_t  hold;

    assign reply_ready = (state == S_EMPTY);
    assign tx_en       = (state == S_PULSE);
    assign tx_data     = hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_EMPTY;
        end else begin
            case (state)
                S_EMPTY: if (reply_valid) state <= S_HOLD;
                S_HOLD:  if (!tx_busy) state <= S_PULSE;
                S_PULSE: state <= S_SETTLE;
                // line gets a cycle to raise tx_busy
                default: state <= S_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reply_valid && reply_ready) begin
            hold <= reply_byte;
        end
    end

    assert property (@(posedge clk) disable iff (reset) tx_en |-> !tx_busy)
        else $error("tx_en raised while the line was busy");

endmodule

/* cnn_top.sv */
module cnn_top
    import cnn_host_pkg::*;
    import cnn_layer_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  data_t rx_data,
    input  logic  rx_rdy,
    output data_t tx_data,
    output logic  tx_en,
    input  logic  tx_busy,
    output logic  busy
);

    host_cmd_t cmd;
    mem_wr_t   host_wr;
    data_t     reply_byte;
    logic      reply_valid;
    logic      reply_ready;

    cmd_decode decode_i (
        .clk     (clk),
        .reset   (reset),
        .rx_data (rx_data),
        .rx_rdy  (rx_rdy),
        .cmd     (cmd),
        .host_wr (host_wr)
    );

    layer_execute exec_i (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .host_wr     (host_wr),
        .reply_ready (reply_ready),
        .reply_byte  (reply_byte),
        .reply_valid (reply_valid),
        .busy        (busy)
    );

    reply_sender sender_i (
        .clk         (clk),
        .reset       (reset),
        .reply_byte  (reply_byte),
        .reply_valid (reply_valid),
        .reply_ready (reply_ready),
        .tx_data     (tx_data),
        .tx_en       (tx_en),
        .tx_busy     (tx_busy)
    );

endmodule

/* tb_cnn_model.svh */
`ifndef TB_CNN_MODEL_SVH
`define TB_CNN_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'h0632fb2e;

// mirror of the scratch memory
logic [7:0] model_mem [256];

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function automatic int rand_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        st = lfsr_next(st);
        v  = {v[30:0], st[0]};
    end
    return int'(v);
endfunction

function automatic logic [7:0] mem_at(int a);
    return model_mem[8'(a)];
endfunction

function automatic void mem_set(int a, logic [7:0] v);
    model_mem[8'(a)] = v;
endfunction

// same-size correlation, kernel centred on the output pixel
function automatic logic [7:0] conv_pixel(int r, int c);
    logic [7:0] sum;
    int         tr;
    int         tc;
    int         pr;
    int         pc;
    int         prod;
    sum = '0;
    for (tr = 0; tr < `CNN_KER_DIM; tr++) begin
        for (tc = 0; tc < `CNN_KER_DIM; tc++) begin
            pr = r + tr - `CNN_KER_DIM / 2;
            pc = c + tc - `CNN_KER_DIM / 2;
            // padding taps add nothing
            if (pr >= 0 && pr < `CNN_PIC_DIM && pc >= 0 && pc < `CNN_PIC_DIM) begin
                prod = int'(mem_at(`CNN_PIC_BASE + pr * `CNN_PIC_DIM + pc)) *
                       int'(mem_at(`CNN_KER_BASE + tr * `CNN_KER_DIM + tc));
                sum  = sum + 8'(prod);
            end
        end
    end
    return sum;
endfunction

// flags bit 0 adds the bias, bit 1 pools
function automatic void model_layer(logic [1:0] flags);
    int         r;
    int         c;
    int         d;
    int         a;
    logic [7:0] m;
    logic [7:0] v;
    for (r = 0; r < `CNN_PIC_DIM; r++) begin
        for (c = 0; c < `CNN_PIC_DIM; c++) begin
            a = `CNN_CONV_BASE + r * `CNN_PIC_DIM + c;
            mem_set(a, conv_pixel(r, c));
            if (flags[0]) begin
                mem_set(a, mem_at(a) + mem_at(`CNN_BIAS_ADDR));
            end
        end
    end
    if (flags[1]) begin
        for (r = 0; r < `CNN_PIC_DIM / 2; r++) begin
            for (c = 0; c < `CNN_PIC_DIM / 2; c++) begin
                m = '0;
                for (d = 0; d < 4; d++) begin
                    a = `CNN_CONV_BASE + (2 * r + d / 2) * `CNN_PIC_DIM + 2 * c + d % 2;
                    v = mem_at(a);
                    if (v > m) begin
                        m = v;
                    end
                end
                mem_set(`CNN_POOL_BASE + r * (`CNN_PIC_DIM / 2) + c, m);
            end
        end
    end
endfunction

`endif

/* tb_cnn_top.sv */
`include "cnn_config.svh"

module tb_cnn_top
    import cnn_layer_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_STEPS   = 22;
    // one conv layer plus a full read under back-pressure
    localparam int STEP_CYCLES = 100 * 40 + 256 * 12;
    localparam int WATCHDOG_NS = NUM_STEPS * STEP_CYCLES * CLK_PERIOD;

    logic  clk = 1'b0;
    logic  reset;
    data_t rx_data;
    logic  rx_rdy;
    data_t tx_data;
    logic  tx_en;
    logic  tx_busy;
    logic  busy;

    logic [31:0] stim_lfsr;
    logic [31:0] line_lfsr;
    int          busy_left;
    data_t       line_bytes [$];

    `include "tb_cnn_model.svh"

    cnn_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .rx_data (rx_data),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_en   (tx_en),
        .tx_busy (tx_busy),
        .busy    (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string name, int expected, int actual);
        if (expected != actual) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_byte(data_t b);
        rx_data = b;
        rx_rdy  = 1'b1;
        @(negedge clk);
        rx_rdy  = 1'b0;
        // sometimes an idle cycle between bytes
        if (rand_bits(stim_lfsr, 1) != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic send_cmd(data_t op, int arg0, int arg1);
        send_byte(op);
        send_byte(8'(arg0));
        send_byte(8'(arg1));
    endtask

    task automatic write_random(int addr, int len);
        data_t b;
        int    i;
        send_cmd(`CNN_OP_WRITE, addr, len);
        for (i = 0; i < len; i++) begin
            b = 8'(rand_bits(stim_lfsr, 8));
            mem_set(addr + i, b);
            send_byte(b);
        end
    endtask

    task automatic wait_idle(string name);
        check_value({name, " busy raised"}, 1, int'(busy));
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic read_check(string name, int addr, int len);
        data_t got;
        int    i;
        check_value({name, " stale bytes"}, 0, line_bytes.size());
        send_cmd(`CNN_OP_READ, addr, len);
        wait_idle(name);
        // the sender still holds the last byte
        check_value({name, " byte count"}, (len > 0) ? len - 1 : 0, line_bytes.size());
        while (line_bytes.size() < len) begin
            @(negedge clk);
        end
        for (i = 0; i < len; i++) begin
            got = line_bytes.pop_front();
            check_value($sformatf("%s addr %0d", name, (addr + i) % 256),
                        int'(mem_at(addr + i)), int'(got));
        end
    endtask

    task automatic run_layer(string name, int flags);
        send_cmd(`CNN_OP_CONV, flags, 0);
        wait_idle(name);
        model_layer(2'(flags));
    endtask

    task automatic send_stray(string name);
        data_t b;
        b = 8'(rand_bits(stim_lfsr, 8));
        if (b == `CNN_OP_WRITE || b == `CNN_OP_READ || b == `CNN_OP_CONV) begin
            b = b ^ 8'h80;
        end
        send_byte(b);
        check_value({name, " busy"}, 0, int'(busy));
        @(negedge clk);
        check_value({name, " busy"}, 0, int'(busy));
    endtask

    // line model, busy for 0 to 7 cycles after each strobe
    initial begin
        tx_busy   = 1'b0;
        busy_left = 0;
        line_lfsr = LFSR_SEED;
        forever begin
            @(negedge clk);
            if (tx_en) begin
                check_value("tx_en while tx_busy", 0, int'(tx_busy));
            end
            if (busy_left > 0) begin
                tx_busy   = 1'b1;
                busy_left = busy_left - 1;
            end else begin
                tx_busy = 1'b0;
            end
            if (tx_en) begin
                line_bytes.push_back(tx_data);
                busy_left = rand_bits(line_lfsr, 3);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out waiting for the DUT");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int round;
        int addr;
        int len;
        reset     = 1'b1;
        rx_data   = '0;
        rx_rdy    = 1'b0;
        stim_lfsr = LFSR_SEED;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // defined data everywhere first
        write_random(0, 128);
        write_random(128, 128);

        // write and read back
        write_random(250, 20);
        read_check("wrap read", 250, 20);
        write_random(40, 0);
        read_check("empty read", 40, 0);
        for (round = 0; round < 6; round++) begin
            addr = rand_bits(stim_lfsr, 8);
            len  = rand_bits(stim_lfsr, 8);
            write_random(addr, len);
            read_check("random read", addr, len);
        end

        // plain convolution
        write_random(`CNN_PIC_BASE, 100);
        write_random(`CNN_KER_BASE, 25);
        write_random(`CNN_BIAS_ADDR, 1);
        write_random(`CNN_POOL_BASE, 25);
        run_layer("conv", 0);
        read_check("conv only", `CNN_CONV_BASE, 100);

        // bias pass, pool region left alone
        run_layer("conv bias", 1);
        read_check("conv bias", `CNN_CONV_BASE, 100);
        read_check("pool untouched", `CNN_POOL_BASE, 25);

        // new picture through all three passes
        write_random(`CNN_PIC_BASE, 100);
        run_layer("conv bias pool", 3);
        read_check("biased conv", `CNN_CONV_BASE, 100);
        read_check("max pool", `CNN_POOL_BASE, 25);

        // whole memory under back-pressure
        read_check("full read", 0, 255);
        read_check("full read last", 255, 1);

        // unknown opcodes between commands
        for (round = 0; round < 4; round++) begin
            send_stray("stray byte");
            send_stray("stray byte");
            addr = rand_bits(stim_lfsr, 8);
            len  = rand_bits(stim_lfsr, 5);
            write_random(addr, len);
            send_stray("stray byte");
            read_check("read after stray", addr, len);
        end

        check_value("leftover bytes", 0, line_bytes.size());
        $display("TB PASSED");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
cnn_host_pkg.sv
cnn_layer_pkg.sv
scratch_ram.sv
cmd_decode.sv
layer_execute.sv
reply_sender.sv
cnn_top.sv
tb_cnn_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_cnn_top -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cnn_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0
